// File: build.f
hw/merge_pkg.sv
hw/merge_ctrl.sv
hw/cross_stage.sv
hw/clean_stage.sv
hw/sideband_pipe.sv
hw/bitonic_merge_16.sv
test/tb_bitonic_merge_16.sv

// File: test/tb_bitonic_merge_16.sv
`timescale 1ns/10ps

module tb_bitonic_merge_16;

   import merge_pkg::*;

   localparam int TIMEOUT = 20;

   typedef key_t [2*LANES-1:0] key_pool_t;

   // One delivered set with its sideband
   typedef struct packed {
      merge_set_t set;
      logic       sw;
      lane_vec_t  top;
   } exp_t;

   logic       i_clk = 1'b0;
   logic       i_arst_n;
   logic       i_stall;
   merge_set_t i_set;
   logic       i_switch;
   lane_vec_t  i_top_tuple;
   merge_set_t o_set;
   logic       o_switch;
   lane_vec_t  o_top_tuple;
   logic       o_stall;

   integer            seed;
   int                mismatch_cnt = 0;
   int                fail_cnt = 0;
   exp_t              exp_q[$];
   exp_t              exp_e;
   exp_t              cur_out;
   exp_t              last_out = '0;
   logic [STAGES-1:0] stall_hist = '1;

   bitonic_merge_16 u_bitonic_merge_16 (
      .i_clk       (i_clk),
      .i_arst_n    (i_arst_n),
      .i_stall     (i_stall),
      .i_set       (i_set),
      .i_switch    (i_switch),
      .i_top_tuple (i_top_tuple),
      .o_set       (o_set),
      .o_switch    (o_switch),
      .o_top_tuple (o_top_tuple),
      .o_stall     (o_stall)
   );

   always #5 i_clk = ~i_clk;

   // Insertion sort over the first n keys
   function automatic key_pool_t sort_keys(input key_pool_t k, input int n);
      key_t t;
      int   j;
      for (int i = 1; i < n; i++) begin
         t = k[i];
         j = i - 1;
         while (j >= 0 && k[j] > t) begin
            k[j+1] = k[j];
            j--;
         end
         k[j+1] = t;
      end
      return k;
   endfunction

   // Reference merge sorts all 16 keys and splits them in half
   function automatic merge_set_t merge_model(input merge_set_t s);
      key_pool_t  pool;
      merge_set_t r;
      for (int i = 0; i < LANES; i++) begin
         pool[i]       = s.lo[i];
         pool[LANES+i] = s.hi[i];
      end
      pool = sort_keys(pool, 2 * LANES);
      for (int i = 0; i < LANES; i++) begin
         r.lo[i] = pool[i];
         r.hi[i] = pool[LANES+i];
      end
      return r;
   endfunction

   // Mode 1 gives many duplicates and modes 2 and 3 split the key range
   function automatic key_t rand_key(input int mode);
      logic [95:0] r;
      r = {$random(seed), $random(seed), $random(seed)};
      case (mode)
         1: return key_t'(r[2:0]);
         2: return {1'b1, r[KEY_W-2:0]};
         3: return {1'b0, r[KEY_W-2:0]};
         default: return r[KEY_W-1:0];
      endcase
   endfunction

   function automatic lane_vec_t rand_list(input int mode);
      key_pool_t pool;
      lane_vec_t v;
      pool = '0;
      for (int i = 0; i < LANES; i++) begin
         pool[i] = rand_key(mode);
      end
      pool = sort_keys(pool, LANES);
      for (int i = 0; i < LANES; i++) begin
         v[i] = pool[i];
      end
      return v;
   endfunction

   task automatic drive_set(input merge_set_t s, input logic sw, input lane_vec_t top,
                            input logic stall);
      exp_t e;
      @(posedge i_clk);
      #1;
      i_stall     = stall;
      i_set       = s;
      i_switch    = sw;
      i_top_tuple = top;
      if (!stall) begin
         e.set = merge_model(s);
         e.sw  = sw;
         e.top = top;
         exp_q.push_back(e);
      end
   endtask

   task automatic drive_random(input logic stall, input int lo_mode, input int hi_mode);
      merge_set_t s;
      lane_vec_t  top;
      logic       sw;
      s.lo = rand_list(lo_mode);
      s.hi = rand_list(hi_mode);
      for (int i = 0; i < LANES; i++) begin
         top[i] = rand_key(0);
      end
      sw = 1'($random(seed));
      drive_set(s, sw, top, stall);
   endtask

   // Stop feeding and wait for every pending set to come out
   task automatic drain_pipe();
      int n;
      @(posedge i_clk);
      #1;
      i_stall = 1'b1;
      n = 0;
      while (exp_q.size() != 0 && n < TIMEOUT) begin
         @(posedge i_clk);
         n++;
      end
      if (exp_q.size() != 0) begin
         fail_cnt++;
         $display("timeout at %0t: no output arrived for %0d pending sets", $time,
                  exp_q.size());
         exp_q.delete();
      end
   endtask

   task automatic check_reset_state();
      assert (o_stall === 1'b1) else begin
         mismatch_cnt++;
         $display("mismatch at %0t: o_stall low after reset", $time);
      end
      assert (o_set === '0) else begin
         mismatch_cnt++;
         $display("mismatch at %0t: o_set not zero after reset", $time);
      end
      assert (o_switch === 1'b0) else begin
         mismatch_cnt++;
         $display("mismatch at %0t: o_switch high after reset", $time);
      end
   endtask

   task automatic merge_one_set();
      int n;
      drive_random(1'b0, 0, 0);
      @(posedge i_clk);
      #1;
      i_stall = 1'b1;
      n = 1;
      while (o_stall && n < TIMEOUT) begin
         @(posedge i_clk);
         #1;
         n++;
      end
      if (o_stall) begin
         fail_cnt++;
         $display("timeout at %0t: no output arrived for the single set", $time);
      end else begin
         assert (n == STAGES) else begin
            mismatch_cnt++;
            $display("mismatch at %0t: latency %0d edges, expected %0d", $time, n, STAGES);
         end
      end
      drain_pipe();
   endtask

   task automatic stream_sets();
      for (int i = 0; i < 20; i++) begin
         drive_random(1'b0, (i % 4 == 3) ? 1 : 0, 0);
      end
      drain_pipe();
   endtask

   task automatic insert_bubbles();
      for (int i = 0; i < 40; i++) begin
         drive_random(($random(seed) & 3) == 0, 0, 0);
      end
      drain_pipe();
   endtask

   task automatic carry_sideband();
      for (int i = 0; i < 30; i++) begin
         drive_random(1'($random(seed)), 0, 1);
      end
      drain_pipe();
   endtask

   task automatic merge_edge_keys();
      merge_set_t s;
      key_t       k;
      k    = rand_key(0);
      s.lo = {LANES{k}};
      s.hi = {LANES{k}};
      drive_set(s, 1'b1, '0, 1'b0);
      drive_set('0, 1'b0, '1, 1'b0);
      drive_set('1, 1'b1, '0, 1'b0);
      // Every low key above every high key
      s.lo = '1;
      s.hi = '0;
      drive_set(s, 1'b0, '1, 1'b0);
      s.lo = rand_list(2);
      s.hi = rand_list(3);
      drive_set(s, 1'b1, rand_list(0), 1'b0);
      s.lo = rand_list(1);
      s.hi = rand_list(1);
      drive_set(s, 1'b0, rand_list(1), 1'b0);
      drain_pipe();
   endtask

   // Output monitor samples mid-cycle
   always @(negedge i_clk) begin
      cur_out = {o_set, o_switch, o_top_tuple};
      if (i_arst_n) begin
         assert (o_stall == stall_hist[STAGES-1]) else begin
            mismatch_cnt++;
            $display("mismatch at %0t: o_stall %b, expected %b", $time, o_stall,
                     stall_hist[STAGES-1]);
         end
         if (!o_stall) begin
            if (exp_q.size() == 0) begin
               fail_cnt++;
               $display("error at %0t: a set came out that was never driven", $time);
            end else begin
               exp_e = exp_q.pop_front();
               assert (o_set == exp_e.set) else begin
                  mismatch_cnt++;
                  $display("mismatch at %0t: o_set differs from merge model", $time);
               end
               assert (o_switch == exp_e.sw) else begin
                  mismatch_cnt++;
                  $display("mismatch at %0t: o_switch %b, expected %b", $time, o_switch,
                           exp_e.sw);
               end
               assert (o_top_tuple == exp_e.top) else begin
                  mismatch_cnt++;
                  $display("mismatch at %0t: o_top_tuple differs from driven tuple", $time);
               end
               last_out = exp_e;
            end
         end else begin
            // Bubble cycles hold the previous outputs
            assert (cur_out == last_out) else begin
               mismatch_cnt++;
               $display("mismatch at %0t: outputs changed during a stall bubble", $time);
            end
         end
      end
      stall_hist = {stall_hist[STAGES-2:0], i_stall};
   end

   initial begin
      seed        = 32'hdbbb_f111;
      i_arst_n    = 1'b0;
      i_stall     = 1'b1;
      i_set       = '0;
      i_switch    = 1'b0;
      i_top_tuple = '0;
      repeat (5) @(posedge i_clk);
      #1;
      i_arst_n = 1'b1;

      check_reset_state();
      merge_one_set();
      stream_sets();
      insert_bubbles();
      carry_sideband();
      merge_edge_keys();

      $display("Error counts: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
      if (mismatch_cnt == 0 && fail_cnt == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

// File: hw/bitonic_merge_16.sv
`timescale 1ns/10ps

module bitonic_merge_16 (
   input  logic                  i_clk,
   input  logic                  i_arst_n,
   input  logic                  i_stall,
   input  merge_pkg::merge_set_t i_set,
   input  logic                  i_switch,
   input  merge_pkg::lane_vec_t  i_top_tuple,
   output merge_pkg::merge_set_t o_set,
   output logic                  o_switch,
   output merge_pkg::lane_vec_t  o_top_tuple,
   output logic                  o_stall
);

   import merge_pkg::*;

   stage_en_t  stage_en;
   merge_set_t set_cross;
   merge_set_t set_dist4;
   merge_set_t set_dist2;

   merge_ctrl u_ctrl (
      .i_clk      (i_clk),
      .i_arst_n   (i_arst_n),
      .i_stall    (i_stall),
      .o_stage_en (stage_en),
      .o_stall    (o_stall)
   );

   cross_stage u_cross (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_en     (stage_en[0]),
      .i_set    (i_set),
      .o_set    (set_cross)
   );

   // Bitonic halves are cleaned at distances 4, 2 and 1
   clean_stage #(.DIST(4)) u_clean_4 (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_en     (stage_en[1]),
      .i_set    (set_cross),
      .o_set    (set_dist4)
   );

   clean_stage #(.DIST(2)) u_clean_2 (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_en     (stage_en[2]),
      .i_set    (set_dist4),
      .o_set    (set_dist2)
   );

   clean_stage #(.DIST(1)) u_clean_1 (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_en     (stage_en[3]),
      .i_set    (set_dist2),
      .o_set    (o_set)
   );

   sideband_pipe #(.payload_t(logic)) u_switch_pipe (
      .i_clk      (i_clk),
      .i_arst_n   (i_arst_n),
      .i_stage_en (stage_en),
      .i_data     (i_switch),
      .o_data     (o_switch)
   );

   sideband_pipe #(.payload_t(lane_vec_t)) u_top_pipe (
      .i_clk      (i_clk),
      .i_arst_n   (i_arst_n),
      .i_stage_en (stage_en),
      .i_data     (i_top_tuple),
      .o_data     (o_top_tuple)
   );

   // Whole network: a delivered set comes out as one ascending run of 16
   for (genvar j = 0; j < LANES - 1; j++) begin : g_out_chk
      a_out_sorted : assert property (
         @(posedge i_clk) disable iff (!i_arst_n)
         !o_stall |-> (o_set.lo[j] <= o_set.lo[j+1] && o_set.hi[j] <= o_set.hi[j+1])
      ) else $error("output set not ascending at slot %0d", j);
   end

   a_out_split : assert property (
      @(posedge i_clk) disable iff (!i_arst_n)
      !o_stall |-> (o_set.lo[LANES-1] <= o_set.hi[0])
   ) else $error("largest low key exceeds smallest high key");

endmodule

// File: hw/sideband_pipe.sv
`timescale 1ns/10ps

module sideband_pipe #(
   parameter type payload_t = logic
) (
   input  logic                 i_clk,
   input  logic                 i_arst_n,
   input  merge_pkg::stage_en_t i_stage_en,
   input  payload_t             i_data,
   output payload_t             o_data
);

   import merge_pkg::*;

   // One slot per datapath stage, moved by the same enables
   payload_t pipe_q [STAGES];

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         for (int k = 0; k < STAGES; k++) begin
            pipe_q[k] <= '0;
         end
      end else begin
         if (i_stage_en[0]) begin
            pipe_q[0] <= i_data;
         end
         for (int k = 1; k < STAGES; k++) begin
            if (i_stage_en[k]) begin
               pipe_q[k] <= pipe_q[k-1];
            end
         end
      end
   end

   assign o_data = pipe_q[STAGES-1];

endmodule

// File: hw/clean_stage.sv
`timescale 1ns/10ps

module clean_stage #(
   parameter int DIST = 4
) (
   input  logic                  i_clk,
   input  logic                  i_arst_n,
   input  logic                  i_en,
   input  merge_pkg::merge_set_t i_set,
   output merge_pkg::merge_set_t o_set
);

   import merge_pkg::*;

   merge_set_t set_d;

   if (DIST < 1 || DIST >= LANES || (DIST & (DIST - 1)) != 0) begin : g_bad_dist
      $error("clean_stage DIST must be a power of two below LANES");
   end

   // Half cleaner on one lane vector
   // Pair i maps to lower slot p with the DIST bit clear
   function automatic lane_vec_t clean(input lane_vec_t v);
      lane_vec_t r;
      int        p;
      r = v;
      for (int i = 0; i < LANES / 2; i++) begin
         p = (i / DIST) * 2 * DIST + (i % DIST);
         if (v[p] > v[p+DIST]) begin
            r[p]      = v[p+DIST];
            r[p+DIST] = v[p];
         end
      end
      return r;
   endfunction

   // lo and hi are cleaned independently
   always_comb begin
      set_d.lo = clean(i_set.lo);
      set_d.hi = clean(i_set.hi);
   end

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_set <= '0;
      end else if (i_en) begin
         o_set <= set_d;
      end
   end

   for (genvar i = 0; i < LANES / 2; i++) begin : g_chk
      localparam int P = (i / DIST) * 2 * DIST + (i % DIST);

      a_pair_order : assert property (
         @(posedge i_clk) disable iff (!i_arst_n)
         i_en |=> (o_set.lo[P] <= o_set.lo[P+DIST] && o_set.hi[P] <= o_set.hi[P+DIST])
      ) else $error("clean stage dist %0d pair at slot %0d out of order", DIST, P);
   end

endmodule

// File: hw/cross_stage.sv
`timescale 1ns/10ps

module cross_stage (
   input  logic                  i_clk,
   input  logic                  i_arst_n,
   input  logic                  i_en,
   input  merge_pkg::merge_set_t i_set,
   output merge_pkg::merge_set_t o_set
);

   import merge_pkg::*;

   merge_set_t set_d;

   // Low key j meets its mirror in the high list
   always_comb begin
      set_d = i_set;
      for (int j = 0; j < LANES; j++) begin
         if (i_set.lo[j] > i_set.hi[LANES-1-j]) begin
            set_d.lo[j]         = i_set.hi[LANES-1-j];
            set_d.hi[LANES-1-j] = i_set.lo[j];
         end
      end
   end

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_set <= '0;
      end else if (i_en) begin
         o_set <= set_d;
      end
   end

   // After the cross compare no low key exceeds its mirrored high key
   for (genvar j = 0; j < LANES; j++) begin : g_chk
      a_split : assert property (
         @(posedge i_clk) disable iff (!i_arst_n)
         i_en |=> (o_set.lo[j] <= o_set.hi[LANES-1-j])
      ) else $error("cross stage pair %0d out of order", j);
   end

endmodule

// File: hw/merge_ctrl.sv
`timescale 1ns/10ps

module merge_ctrl (
   input  logic                 i_clk,
   input  logic                 i_arst_n,
   input  logic                 i_stall,
   output merge_pkg::stage_en_t o_stage_en,
   output logic                 o_stall
);

   import merge_pkg::*;

   // Tap k holds the input stall from k+1 edges back
   logic [STAGES-1:0] stall_q;

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         stall_q <= '1;
      end else begin
         stall_q <= {stall_q[STAGES-2:0], i_stall};
      end
   end

   // Stage 0 captures straight from the input level
   assign o_stage_en = ~{stall_q[STAGES-2:0], i_stall};

   // Bubble leaves with the last stage
   assign o_stall = stall_q[STAGES-1];

   a_stall_delay : assert property (
      @(posedge i_clk) disable iff (!i_arst_n)
      1'b1 |-> ##STAGES (o_stall == $past(i_stall, STAGES))
   ) else $error("output stall does not match input stall %0d cycles earlier", STAGES);

endmodule

// File: hw/merge_pkg.sv
package merge_pkg;

   localparam int KEY_W  = 80;
   localparam int LANES  = 8;
   localparam int STAGES = 4;

   typedef logic [KEY_W-1:0] key_t;

   // Slot 0 holds the smallest key
   typedef key_t [LANES-1:0] lane_vec_t;

   // hi[j] sits at network position LANES+j
   typedef struct packed {
      lane_vec_t hi;
      lane_vec_t lo;
   } merge_set_t;

   // One enable per pipeline stage
   typedef logic [STAGES-1:0] stage_en_t;

endpackage
